//--- files.f
common/ddr_mux_pkg.sv
port/ddr_line_ram.sv
port/ddr_write_fifo.sv
port/ddr_port.sv
rtl/ddr_arbiter.sv
rtl/ddr_mux_top.sv
verif/ddr_mem_model.sv
verif/ddr_mux_tb.sv

//--- Bender.yml
package:
  name: ddr_mux

sources:
  - common/ddr_mux_pkg.sv
  - port/ddr_line_ram.sv
  - port/ddr_write_fifo.sv
  - port/ddr_port.sv
  - rtl/ddr_arbiter.sv
  - rtl/ddr_mux_top.sv
  - target: simulation
    files:
      - verif/ddr_mem_model.sv
      - verif/ddr_mux_tb.sv

//--- verif/ddr_mux_tb.sv
`timescale 1ns/1ps

module ddr_mux_tb;

	localparam int NUM_PORTS    = 3;
	localparam int RAND_OPS     = 40;
	// reads and writes issued before the random phase
	localparam int DIRECTED_TXN = 18;
	localparam int NUM_TXN      = DIRECTED_TXN + NUM_PORTS * RAND_OPS;
	localparam int WORDS        = 4096;

	// byte address of the RAM region
	localparam logic [31:0] RAM_BASE = 32'h3000_0000;

	logic CLK;
	logic rst_pulse;

	ddr_mux_pkg::port_req_t port_req [NUM_PORTS];
	ddr_mux_pkg::port_rsp_t port_rsp [NUM_PORTS];
	ddr_mux_pkg::mem_req_t  mem_req;
	ddr_mux_pkg::mem_rsp_t  mem_rsp;

	int burst_count;
	int seed;
	int mismatch_count;
	int fail_count;
	int bursts_before;

	// expected memory, byte lane b of word w at w*8+b
	logic [7:0]  shadow [WORDS*8];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];
	string       name_q [$];

	ddr_mux_top #(
		.NUM_PORTS      (NUM_PORTS),
		.FIFO_DEPTH_LOG2(3)
	) UUT (
		.CLK      (CLK),
		.rst_pulse(rst_pulse),
		.port_req (port_req),
		.port_rsp (port_rsp),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

	ddr_mem_model #(
		.WORDS(WORDS)
	) u_mem (
		.CLK        (CLK),
		.rst_pulse  (rst_pulse),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp),
		.burst_count(burst_count)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [63:0] start_word(input int idx);
		logic [15:0] i16;
		i16 = 16'(idx);
		return {i16, ~i16, i16 ^ 16'hc35a, i16 + 16'h7e21};
	endfunction

	// lowest byte lane of the addressed field
	function automatic int base_lane(input logic [24:0] addr, input logic half);
		if (half) begin
			return (3 - int'(addr[1:0])) * 2;
		end
		return addr[1] ? 0 : 4;
	endfunction

	function automatic logic [31:0] ref_read(input logic [24:0] addr, input logic half);
		int w;
		int b;
		w = int'(addr[13:2]);
		b = base_lane(addr, half);
		if (half) begin
			return {16'h0000, shadow[w*8+b+1], shadow[w*8+b]};
		end
		return {shadow[w*8+b+3], shadow[w*8+b+2], shadow[w*8+b+1], shadow[w*8+b]};
	endfunction

	task automatic shadow_write(input logic [24:0] addr, input logic [31:0] din,
			input logic [3:0] wr, input logic half);
		int w;
		int b;
		int n;
		w = int'(addr[13:2]);
		b = base_lane(addr, half);
		n = half ? 2 : 4;
		for (int k = 0; k < n; k++) begin
			if (wr[k]) begin
				shadow[w*8+b+k] = din[8*k +: 8];
			end
		end
	endtask

	task automatic wait_idle(input int p);
		while (port_rsp[p].busy) begin
			@(negedge CLK);
		end
	endtask

	task automatic do_write(input int p, input logic [24:0] addr, input logic [31:0] din,
			input logic [3:0] wr, input logic half);
		wait_idle(p);
		port_req[p].addr = addr;
		port_req[p].din  = din;
		port_req[p].half = half;
		port_req[p].wr   = wr;
		@(negedge CLK);
		port_req[p].wr = 4'b0000;
		shadow_write(addr, din, wr, half);
		@(negedge CLK);
	endtask

	task automatic do_read(input int p, input logic [24:0] addr, input logic half,
			input string name, input bit expect_hit);
		wait_idle(p);
		port_req[p].addr = addr;
		port_req[p].half = half;
		port_req[p].rd   = 1'b1;
		@(negedge CLK);
		port_req[p].rd = 1'b0;
		if (expect_hit && port_rsp[p].busy) begin
			fail_count++;
			$display("%s: busy rose on a read that should hit the cached line", name);
		end
		wait_idle(p);
		name_q.push_back(name);
		exp_q.push_back(ref_read(addr, half));
		act_q.push_back(port_rsp[p].dout);
		@(negedge CLK);
	endtask

	task automatic random_ops(input int p);
		logic [24:0] addr;
		logic [31:0] r;
		logic [31:0] d;
		logic        half;
		logic [3:0]  wr;
		for (int k = 0; k < RAND_OPS; k++) begin
			r = $random(seed);
			d = $random(seed);
			// four lines per port, regions kept apart by bits 13..12
			addr = {11'd0, 2'(p + 1), 6'd0, r[5:0]};
			half = r[6];
			if (r[7]) begin
				if (half) begin
					wr = {2'b00, (r[9:8] == 2'b00) ? 2'b11 : r[9:8]};
				end else begin
					wr = (r[11:8] == 4'h0) ? 4'hf : r[11:8];
				end
				do_write(p, addr, d, wr, half);
			end else begin
				do_read(p, addr, half, $sformatf("random_p%0d", p), 1'b0);
			end
		end
	endtask

	// memory request fields, sampled mid-cycle on each accepted request
	always @(negedge CLK) begin
		if (!rst_pulse && !mem_rsp.busy && (mem_req.rd || mem_req.we)) begin
			if (mem_req.addr[28:23] !== RAM_BASE[31:26]) begin
				mismatch_count++;
				$display("Mismatch mem_base: expected %h, actual %h", RAM_BASE[31:26],
						mem_req.addr[28:23]);
			end
		end
		if (!rst_pulse && !mem_rsp.busy && mem_req.we) begin
			if (mem_req.burstcnt !== 8'd1) begin
				mismatch_count++;
				$display("Mismatch mem_write_burstcnt: expected %h, actual %h", 8'd1,
						mem_req.burstcnt);
			end
		end
		if (!rst_pulse && !mem_rsp.busy && mem_req.rd) begin
			if (mem_req.burstcnt !== 8'd4) begin
				mismatch_count++;
				$display("Mismatch mem_read_burstcnt: expected %h, actual %h", 8'd4,
						mem_req.burstcnt);
			end
			if (mem_req.be !== 8'hff) begin
				mismatch_count++;
				$display("Mismatch mem_read_be: expected %h, actual %h", 8'hff, mem_req.be);
			end
			if (mem_req.addr[1:0] !== 2'b00) begin
				mismatch_count++;
				$display("Mismatch mem_read_align: expected %h, actual %h", 2'b00,
						mem_req.addr[1:0]);
			end
		end
	end

	// compare process
	initial begin
		string       nm;
		logic [31:0] e;
		logic [31:0] a;
		forever begin
			wait (exp_q.size() > 0);
			nm = name_q.pop_front();
			e  = exp_q.pop_front();
			a  = act_q.pop_front();
			if (a !== e) begin
				mismatch_count++;
				$display("Mismatch %s: expected %h, actual %h", nm, e, a);
			end
		end
	end

	initial begin
		repeat (200 * NUM_TXN) @(posedge CLK);
		$display("watchdog expired before the run completed");
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [63:0] sw;
		seed           = 32'h06095a38;
		mismatch_count = 0;
		fail_count     = 0;
		rst_pulse      = 1'b1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_req[p] = '0;
		end
		for (int w = 0; w < WORDS; w++) begin
			sw = start_word(w);
			for (int b = 0; b < 8; b++) begin
				shadow[w*8+b] = sw[8*b +: 8];
			end
		end
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		rst_pulse = 1'b0;
		@(negedge CLK);

		if (mem_req.rd || mem_req.we) begin
			fail_count++;
			$display("memory rd or we is high after reset");
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (port_rsp[p].busy) begin
				fail_count++;
				$display("port %0d is busy after reset", p);
			end
		end

		// first reads miss and return start contents
		do_read(0, 25'h0040, 1'b0, "reset_miss", 1'b0);
		do_read(0, 25'h0043, 1'b1, "reset_miss_half", 1'b0);

		// 32-bit writes with partial strobes
		do_write(0, 25'h0080, 32'hdeadbeef, 4'b0101, 1'b0);
		do_read(0, 25'h0080, 1'b0, "write32_partial", 1'b0);
		do_write(0, 25'h0082, 32'h12345678, 4'b1111, 1'b0);
		do_read(0, 25'h0082, 1'b0, "write32_full", 1'b0);

		// halfword writes across one word
		for (int k = 0; k < 4; k++) begin
			do_write(0, 25'h00c0 + 25'(k), 32'h1111 * (k + 1), 4'b0011, 1'b1);
		end
		for (int k = 0; k < 4; k++) begin
			do_read(0, 25'h00c0 + 25'(k), 1'b1, $sformatf("write16_%0d", k), 1'b0);
		end

		// hit in the same line after a miss
		do_read(0, 25'h0100, 1'b0, "line_miss", 1'b0);
		bursts_before = burst_count;
		do_read(0, 25'h010d, 1'b1, "line_hit", 1'b1);
		if (burst_count != bursts_before) begin
			fail_count++;
			$display("a read hit started a new memory burst");
		end

		// dirty refetch
		do_write(0, 25'h0104, 32'hcafef00d, 4'b1111, 1'b0);
		bursts_before = burst_count;
		do_read(0, 25'h0104, 1'b0, "dirty_refetch", 1'b0);
		if (burst_count == bursts_before) begin
			fail_count++;
			$display("a read after a write to the cached line did not refetch");
		end

		fork
			random_ops(0);
			random_ops(1);
			random_ops(2);
		join

		wait (exp_q.size() == 0);
		@(negedge CLK);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- verif/ddr_mem_model.sv
`timescale 1ns/1ps

module ddr_mem_model #(
	parameter int WORDS = 4096,
	parameter int SEED  = 32'h06095a38
) (
	input  logic                  CLK,
	input  logic                  rst_pulse,
	input  ddr_mux_pkg::mem_req_t mem_req,
	output ddr_mux_pkg::mem_rsp_t mem_rsp,
	output int                    burst_count
);

	logic [63:0] mem [WORDS];
	logic [11:0] rd_addr;
	logic        rd_active;
	int          delay;
	int          beat;
	int          seed;

	// start contents, every bit of the word index shows up in the data
	function automatic logic [63:0] start_word(input int idx);
		logic [15:0] i16;
		i16 = 16'(idx);
		return {i16, ~i16, i16 ^ 16'hc35a, i16 + 16'h7e21};
	endfunction

	initial begin
		seed = SEED;
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = start_word(i);
		end
	end

	always @(posedge CLK) begin
		if (rst_pulse) begin
			mem_rsp.busy       <= 1'b0;
			mem_rsp.dout       <= '0;
			mem_rsp.dout_ready <= 1'b0;
			rd_active          <= 1'b0;
			burst_count        <= 0;
		end else begin
			mem_rsp.dout_ready <= 1'b0;
			if (!mem_rsp.busy && mem_req.we) begin
				for (int b = 0; b < 8; b++) begin
					if (mem_req.be[b]) begin
						mem[mem_req.addr[11:0]][8*b +: 8] <= mem_req.din[8*b +: 8];
					end
				end
			end
			if (!mem_rsp.busy && mem_req.rd) begin
				rd_active    <= 1'b1;
				rd_addr      <= mem_req.addr[11:0];
				delay        <= $random(seed) & 7;
				beat         <= 0;
				burst_count  <= burst_count + 1;
				mem_rsp.busy <= 1'b0;
			end else if (rd_active) begin
				if (delay > 0) begin
					delay        <= delay - 1;
					mem_rsp.busy <= (($random(seed) & 3) == 0);
				end else begin
					// beats go out back to back with busy low
					mem_rsp.busy       <= 1'b0;
					mem_rsp.dout_ready <= 1'b1;
					mem_rsp.dout       <= mem[{rd_addr[11:2], 2'(beat)}];
					beat               <= beat + 1;
					if (beat == 3) begin
						rd_active <= 1'b0;
					end
				end
			end else begin
				mem_rsp.busy <= (($random(seed) & 3) == 0);
			end
		end
	end

endmodule

//--- rtl/ddr_mux_top.sv
`timescale 1ns/1ps

module ddr_mux_top #(
	parameter int NUM_PORTS       = 3,
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                   CLK,
	input  logic                   rst_pulse,
	input  ddr_mux_pkg::port_req_t port_req [NUM_PORTS],
	output ddr_mux_pkg::port_rsp_t port_rsp [NUM_PORTS],
	output ddr_mux_pkg::mem_req_t  mem_req,
	input  ddr_mux_pkg::mem_rsp_t  mem_rsp
);

	// port to arbiter
	logic [NUM_PORTS-1:0]           wr_pending;
	logic [NUM_PORTS-1:0]           rd_pending;
	ddr_mux_pkg::wr_beat_t          wr_beat [NUM_PORTS];
	logic [ddr_mux_pkg::ADDR_W-5:0] rd_line [NUM_PORTS];

	// arbiter to ports
	logic [NUM_PORTS-1:0] grant_pop;
	logic [NUM_PORTS-1:0] fill_sel;
	logic [NUM_PORTS-1:0] fill_done;
	ddr_mux_pkg::fill_t   fill;

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		ddr_port #(
			.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
		) u_port (
			.CLK       (CLK),
			.rst_pulse (rst_pulse),
			.req       (port_req[i]),
			.rsp       (port_rsp[i]),
			.wr_pending(wr_pending[i]),
			.wr_beat   (wr_beat[i]),
			.grant_pop (grant_pop[i]),
			.rd_pending(rd_pending[i]),
			.rd_line   (rd_line[i]),
			.fill      (fill),
			.fill_sel  (fill_sel[i]),
			.fill_done (fill_done[i])
		);
	end

	ddr_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) u_arbiter (
		.CLK       (CLK),
		.rst_pulse (rst_pulse),
		.wr_pending(wr_pending),
		.rd_pending(rd_pending),
		.wr_beat   (wr_beat),
		.rd_line   (rd_line),
		.grant_pop (grant_pop),
		.fill      (fill),
		.fill_sel  (fill_sel),
		.fill_done (fill_done),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

endmodule

//--- rtl/ddr_arbiter.sv
`timescale 1ns/1ps

module ddr_arbiter #(
	parameter int NUM_PORTS = 3
) (
	input  logic                           CLK,
	input  logic                           rst_pulse,
	input  logic [NUM_PORTS-1:0]           wr_pending,
	input  logic [NUM_PORTS-1:0]           rd_pending,
	input  ddr_mux_pkg::wr_beat_t          wr_beat [NUM_PORTS],
	input  logic [ddr_mux_pkg::ADDR_W-5:0] rd_line [NUM_PORTS],
	output logic [NUM_PORTS-1:0]           grant_pop,
	output ddr_mux_pkg::fill_t             fill,
	output logic [NUM_PORTS-1:0]           fill_sel,
	output logic [NUM_PORTS-1:0]           fill_done,
	output ddr_mux_pkg::mem_req_t          mem_req,
	input  ddr_mux_pkg::mem_rsp_t          mem_rsp
);

	localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
	localparam int CNT_W = $clog2(ddr_mux_pkg::LINE_WORDS);

	ddr_mux_pkg::arb_state_e state;

	logic [IDX_W-1:0]     grant;
	logic [NUM_PORTS-1:0] grant_oh;
	logic [CNT_W-1:0]     word_cnt;

	logic             pick_valid;
	logic             pick_wr;
	logic [IDX_W-1:0] pick_idx;

	// fixed priority, lowest index wins, write before read
	always_comb begin
		pick_valid = 1'b0;
		pick_wr    = 1'b0;
		pick_idx   = '0;
		for (int i = NUM_PORTS - 1; i >= 0; i--) begin
			if (wr_pending[i] || rd_pending[i]) begin
				pick_valid = 1'b1;
				pick_wr    = wr_pending[i];
				pick_idx   = IDX_W'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			grant_oh[i] = (grant == IDX_W'(i));
		end
	end

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			state      <= ddr_mux_pkg::ARB_IDLE;
			grant      <= '0;
			word_cnt   <= '0;
			mem_req.rd <= 1'b0;
			mem_req.we <= 1'b0;
		end else if (!mem_rsp.busy) begin
			// request seen by memory, drop strobes
			mem_req.rd <= 1'b0;
			mem_req.we <= 1'b0;
			case (state)
				ddr_mux_pkg::ARB_IDLE: begin
					if (pick_valid) begin
						grant    <= pick_idx;
						word_cnt <= '0;
						if (pick_wr) begin
							mem_req.we <= 1'b1;
							state      <= ddr_mux_pkg::ARB_WRITE;
						end else begin
							mem_req.rd <= 1'b1;
							state      <= ddr_mux_pkg::ARB_FILL;
						end
					end
				end
				ddr_mux_pkg::ARB_WRITE: begin
					state <= ddr_mux_pkg::ARB_IDLE;
				end
				ddr_mux_pkg::ARB_FILL: begin
					if (mem_rsp.dout_ready) begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == CNT_W'(ddr_mux_pkg::LINE_WORDS - 1)) begin
							state <= ddr_mux_pkg::ARB_IDLE;
						end
					end
				end
				default: state <= ddr_mux_pkg::ARB_IDLE;
			endcase
		end
	end

	// request payload, loaded when a port is granted
	always_ff @(posedge CLK) begin
		if (!mem_rsp.busy && state == ddr_mux_pkg::ARB_IDLE && pick_valid) begin
			if (pick_wr) begin
				mem_req.addr     <= {ddr_mux_pkg::MEM_BASE, wr_beat[pick_idx].word_addr};
				mem_req.din      <= wr_beat[pick_idx].data;
				mem_req.be       <= wr_beat[pick_idx].be;
				mem_req.burstcnt <= 8'd1;
			end else begin
				// line aligned burst
				mem_req.addr     <= {ddr_mux_pkg::MEM_BASE, rd_line[pick_idx], 2'b00};
				mem_req.din      <= '0;
				mem_req.be       <= 8'hff;
				mem_req.burstcnt <= 8'(ddr_mux_pkg::LINE_WORDS);
			end
		end
	end

	// pop once the write beat is accepted
	assign grant_pop = (state == ddr_mux_pkg::ARB_WRITE && !mem_rsp.busy) ? grant_oh : '0;

	always_comb begin
		fill.data  = mem_rsp.dout;
		fill.index = word_cnt;
		fill.valid = (state == ddr_mux_pkg::ARB_FILL) && mem_rsp.dout_ready && !mem_rsp.busy;
	end

	assign fill_sel = (state == ddr_mux_pkg::ARB_FILL) ? grant_oh : '0;

	// last beat of the line releases the port
	assign fill_done = (fill.valid && word_cnt == CNT_W'(ddr_mux_pkg::LINE_WORDS - 1)) ?
			grant_oh : '0;

endmodule

//--- port/ddr_port.sv
`timescale 1ns/1ps

module ddr_port #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                           CLK,
	input  logic                           rst_pulse,
	input  ddr_mux_pkg::port_req_t         req,
	output ddr_mux_pkg::port_rsp_t         rsp,
	output logic                           wr_pending,
	output ddr_mux_pkg::wr_beat_t          wr_beat,
	input  logic                           grant_pop,
	output logic                           rd_pending,
	output logic [ddr_mux_pkg::ADDR_W-5:0] rd_line,
	input  ddr_mux_pkg::fill_t             fill,
	input  logic                           fill_sel,
	input  logic                           fill_done
);

	logic old_rd;
	logic old_wr;
	logic rd_edge;
	logic wr_edge;

	// last read address, its upper bits are the line tag
	logic [ddr_mux_pkg::ADDR_W-1:0] cap_addr;
	logic                           cap_half;
	logic                           dirty;
	logic                           rd_busy;

	// packed write waiting to enter the FIFO
	ddr_mux_pkg::wr_beat_t beat_q;
	ddr_mux_pkg::wr_beat_t beat_pack;
	logic                  push_q;

	logic        fifo_empty;
	logic        fifo_full;
	logic [63:0] line_q;

	assign rd_edge = req.rd && !old_rd;
	assign wr_edge = (|req.wr) && !old_wr;

	// lane packing, address 0 is the high end of the beat
	always_comb begin
		beat_pack.word_addr = req.addr[ddr_mux_pkg::ADDR_W-1:2];
		if (req.half) begin
			beat_pack.data = {4{req.din[15:0]}};
			case (req.addr[1:0])
				2'b00: beat_pack.be = {req.wr[1:0], 6'b000000};
				2'b01: beat_pack.be = {2'b00, req.wr[1:0], 4'b0000};
				2'b10: beat_pack.be = {4'b0000, req.wr[1:0], 2'b00};
				default: beat_pack.be = {6'b000000, req.wr[1:0]};
			endcase
		end else begin
			beat_pack.data = {2{req.din}};
			beat_pack.be   = req.addr[1] ? {4'b0000, req.wr} : {req.wr, 4'b0000};
		end
	end

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			old_rd  <= 1'b0;
			old_wr  <= 1'b0;
			push_q  <= 1'b0;
			dirty   <= 1'b1;
			rd_busy <= 1'b0;
		end else begin
			old_rd <= req.rd;
			old_wr <= |req.wr;
			push_q <= wr_edge;
			if (rd_edge) begin
				// miss on other line or stale data
				if (cap_addr[ddr_mux_pkg::ADDR_W-1:4] != req.addr[ddr_mux_pkg::ADDR_W-1:4] ||
						dirty) begin
					rd_busy <= 1'b1;
				end
				dirty <= 1'b0;
			end else if (fill_done) begin
				rd_busy <= 1'b0;
			end
			// write into the cached line forces a refetch
			if (wr_edge && cap_addr[ddr_mux_pkg::ADDR_W-1:4] == req.addr[ddr_mux_pkg::ADDR_W-1:4]) begin
				dirty <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_edge) begin
			cap_addr <= req.addr;
			cap_half <= req.half;
		end
		if (wr_edge) begin
			beat_q <= beat_pack;
		end
	end

	ddr_write_fifo #(
		.DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) u_fifo (
		.CLK      (CLK),
		.rst_pulse(rst_pulse),
		.push     (push_q),
		.push_beat(beat_q),
		.pop      (grant_pop),
		.head     (wr_beat),
		.empty    (fifo_empty),
		.full     (fifo_full)
	);

	ddr_line_ram u_line (
		.CLK     (CLK),
		.wr_index(fill.index),
		.wr_data (fill.data),
		.wr_en   (fill.valid && fill_sel),
		.rd_index(cap_addr[3:2]),
		.rd_data (line_q)
	);

	// read lane select, halfwords zero-extended
	always_comb begin
		if (cap_half) begin
			case (cap_addr[1:0])
				2'b00: rsp.dout = {16'h0000, line_q[63:48]};
				2'b01: rsp.dout = {16'h0000, line_q[47:32]};
				2'b10: rsp.dout = {16'h0000, line_q[31:16]};
				default: rsp.dout = {16'h0000, line_q[15:0]};
			endcase
		end else begin
			rsp.dout = cap_addr[1] ? line_q[31:0] : line_q[63:32];
		end
		rsp.busy = rd_busy | fifo_full;
	end

	assign wr_pending = !fifo_empty;
	assign rd_pending = rd_busy;
	assign rd_line    = cap_addr[ddr_mux_pkg::ADDR_W-1:4];

endmodule

//--- port/ddr_write_fifo.sv
`timescale 1ns/1ps

module ddr_write_fifo #(
	parameter int DEPTH_LOG2 = 3
) (
	input  logic                  CLK,
	input  logic                  rst_pulse,
	input  logic                  push,
	input  ddr_mux_pkg::wr_beat_t push_beat,
	input  logic                  pop,
	output ddr_mux_pkg::wr_beat_t head,
	output logic                  empty,
	output logic                  full
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	ddr_mux_pkg::wr_beat_t mem [DEPTH];

	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2-1:0] wr_ptr;
	// one bit wider than the pointers
	logic [DEPTH_LOG2:0]   count;

	logic push_ok;
	logic pop_ok;

	// drop push when full, ignore pop when empty
	assign push_ok = push && !full;
	assign pop_ok  = pop && !empty;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push_ok && !pop_ok) begin
				count <= count + 1'b1;
			end else if (pop_ok && !push_ok) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge CLK) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_beat;
		end
	end

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = count[DEPTH_LOG2];

endmodule

//--- port/ddr_line_ram.sv
`timescale 1ns/1ps

module ddr_line_ram (
	input  logic        CLK,
	input  logic [1:0]  wr_index,
	input  logic [63:0] wr_data,
	input  logic        wr_en,
	input  logic [1:0]  rd_index,
	output logic [63:0] rd_data
);

	// one cache line, no reset
	logic [63:0] mem [ddr_mux_pkg::LINE_WORDS];

	// fills are full words
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
	end

	// async read, data follows rd_index in the same cycle
	assign rd_data = mem[rd_index];

endmodule

//--- common/ddr_mux_pkg.sv
package ddr_mux_pkg;

	// client halfword address, bits 25..1
	localparam int ADDR_W = 25;

	// memory bus 64-bit word address
	localparam int MEM_ADDR_W = 29;

	// region prefix, RAM sits at 0x30000000
	localparam logic [5:0] MEM_BASE = 6'b001100;

	// 64-bit words per cache line
	localparam int LINE_WORDS = 4;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [31:0]       din;
		logic [3:0]        wr;
		logic              rd;
		logic              half;
	} port_req_t;

	typedef struct packed {
		logic [31:0] dout;
		logic        busy;
	} port_rsp_t;

	// one packed write, word address is client bits 25..3
	typedef struct packed {
		logic [ADDR_W-3:0] word_addr;
		logic [63:0]       data;
		logic [7:0]        be;
	} wr_beat_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [63:0]           din;
		logic [7:0]            be;
		logic [7:0]            burstcnt;
		logic                  rd;
		logic                  we;
	} mem_req_t;

	typedef struct packed {
		logic        busy;
		logic [63:0] dout;
		logic        dout_ready;
	} mem_rsp_t;

	// fill beat, shared by all ports
	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  index;
		logic        valid;
	} fill_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WRITE,
		ARB_FILL
	} arb_state_e;

endpackage
